//--- cmdbuffer/ioCommandBuffer.sv
module ioCommandBuffer (
    input  logic     clk,
    input  logic     rstN,
    ioIssueIf.buffer issue,
    ioPortIf.buffer  port
);
    import ioPkg::*;

    cmdKind_e  kind;
    wordIdx_t  wordIdx;
    logic      isStore;
    logic      upperByte;
    logic      releaseCmd;
    logic      inXfer;
    logic      outXfer;
    logic      active;
    minorOp_t  opHeld;
    regDest_t  regDestHeld;
    dataWord_t addrHeld;
    dataWord_t bufWord [bufWords];
    dataWord_t alignedWord [bufWords];

    assign kind    = cmdKind_e'(issue.op[3:2]);
    assign wordIdx = wordIdx_t'(issue.addr[2:1]);
    assign isStore = (kind == kindStore);

    // half-word always covers the upper byte, a byte only at odd addresses.
    assign upperByte = (issue.op[1:0] != 2'b00) || issue.addr[0];

    // line goes out on the upper byte of the last word, other kinds go at once.
    assign releaseCmd = !isStore || ((wordIdx == wordIdx_t'(bufWords - 1)) && upperByte);

    assign inXfer  = issue.req && issue.ack;
    assign outXfer = port.ack && port.req;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active <= 1'b0;
        end else if (inXfer) begin
            active <= releaseCmd;
        end else if (outXfer) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opHeld      <= '0;
            regDestHeld <= '0;
            addrHeld    <= '0;
        end else if (inXfer && releaseCmd) begin
            opHeld      <= issue.op;
            regDestHeld <= issue.regDest;
            addrHeld    <= issue.addr;
        end
    end

    generate
        for (genvar i = 0; i < bufWords; i++) begin : gAlign
            ioStoreAlign uAlign (
                .op      (issue.op),
                .addr    (issue.addr),
                .data    (issue.data),
                .oldWord (bufWord[i]),
                .newWord (alignedWord[i])
            );
        end
    endgenerate

    // words are not cleared on release, the next line starts from them.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < bufWords; i++) begin
                bufWord[i] <= '0;
            end
        end else if (inXfer && isStore) begin
            bufWord[wordIdx] <= alignedWord[wordIdx];
        end
    end

    assign issue.req    = !active;  // one command in flight.
    assign port.ack     = active;
    assign port.op      = opHeld;
    assign port.regDest = regDestHeld;
    assign port.addr    = addrHeld;
    assign port.line    = {bufWord[3], bufWord[2], bufWord[1], bufWord[0]};

endmodule

//--- cmdbuffer/ioStoreAlign.sv
module ioStoreAlign (
    input  ioPkg::minorOp_t  op,
    input  ioPkg::dataWord_t addr,
    input  ioPkg::dataWord_t data,
    input  ioPkg::dataWord_t oldWord,
    output ioPkg::dataWord_t newWord
);

    logic byteStore;

    // sizes above a half-word fill the whole word here too.
    assign byteStore = (op[1:0] == 2'b00);

    always_comb begin
        if (!byteStore) begin
            newWord = data;
        end else if (addr[0]) begin
            newWord = {data[7:0], oldWord[7:0]};  // high byte.
        end else begin
            newWord = {oldWord[15:8], data[7:0]};
        end
    end

endmodule

//--- common/ioIssueIf.sv
interface ioIssueIf;
    import ioPkg::*;

    minorOp_t  op;
    regDest_t  regDest;
    dataWord_t addr;
    dataWord_t data;
    logic      req;  // buffer can take a command.
    logic      ack;  // issuer offers a command.

    modport issuer (
        output op, regDest, addr, data, ack,
        input  req
    );

    modport buffer (
        input  op, regDest, addr, data, ack,
        output req
    );

endinterface

//--- common/ioPkg.sv
package ioPkg;

    localparam int dataWidth    = 16;
    localparam int portBytes    = 8;
    localparam int bufWords     = 4;
    localparam int portCount    = 4;
    localparam int regAddrWidth = 4;

    typedef logic [dataWidth-1:0]     dataWord_t;  // data or byte address.
    typedef logic [portBytes*8-1:0]   portLine_t;
    typedef logic [regAddrWidth-1:0]  regDest_t;
    typedef logic [3:0]               minorOp_t;

    // buffer word within a line, address bits [2:1].
    typedef logic [1:0]               wordIdx_t;

    // port register, address bits [4:3].
    typedef logic [1:0]               portIdx_t;

    // minor opcode bits [3:2].
    typedef enum logic [1:0] {
        kindOther      = 2'b00,
        kindStore      = 2'b01,
        kindAtomicLoad = 2'b10,
        kindStatusLoad = 2'b11
    } cmdKind_e;

    typedef enum logic [1:0] {
        issueIdle = 2'b00,  // queue empty.
        issueOne  = 2'b01,
        issueTwo  = 2'b10   // queue full.
    } issueState_e;

endpackage

//--- common/ioPortIf.sv
interface ioPortIf;
    import ioPkg::*;

    minorOp_t  op;
    regDest_t  regDest;
    dataWord_t addr;
    portLine_t line;  // gathered store line.
    logic      ack;   // released command is held.
    logic      req;   // target is not stalled.

    modport buffer (
        output op, regDest, addr, line, ack,
        input  req
    );

    modport target (
        input  op, regDest, addr, line, ack,
        output req
    );

endinterface

//--- issue/ioCommandIssuer.sv
module ioCommandIssuer (
    input  logic             clk,
    input  logic             rstN,
    input  logic             cmdValid,
    output logic             cmdReady,
    input  ioPkg::minorOp_t  cmdOp,
    input  ioPkg::regDest_t  cmdRegDest,
    input  ioPkg::dataWord_t cmdAddr,
    input  ioPkg::dataWord_t cmdData,
    ioIssueIf.issuer         issue
);
    import ioPkg::*;

    issueState_e state;
    minorOp_t    opQ [2];
    regDest_t    regDestQ [2];
    dataWord_t   addrQ [2];
    dataWord_t   dataQ [2];
    logic        enq;
    logic        deq;
    logic        enqSlot;

    assign cmdReady = (state != issueTwo);
    assign enq      = cmdValid && cmdReady;
    assign deq      = issue.ack && issue.req;

    // new entry lands at the head when the queue is, or is becoming, empty.
    assign enqSlot = !((state == issueIdle) || (state == issueOne && deq));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= issueIdle;
        end else begin
            case (state)
                issueIdle: begin
                    if (enq) state <= issueOne;
                end
                issueOne: begin
                    if (enq && !deq) begin
                        state <= issueTwo;
                    end else if (deq && !enq) begin
                        state <= issueIdle;
                    end
                end
                issueTwo: begin
                    if (deq) state <= issueOne;
                end
                default: state <= issueIdle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2; i++) begin
                opQ[i]      <= '0;
                regDestQ[i] <= '0;
                addrQ[i]    <= '0;
                dataQ[i]    <= '0;
            end
        end else begin
            if (deq) begin  // second entry moves up.
                opQ[0]      <= opQ[1];
                regDestQ[0] <= regDestQ[1];
                addrQ[0]    <= addrQ[1];
                dataQ[0]    <= dataQ[1];
            end
            if (enq) begin
                opQ[enqSlot]      <= cmdOp;
                regDestQ[enqSlot] <= cmdRegDest;
                addrQ[enqSlot]    <= cmdAddr;
                dataQ[enqSlot]    <= cmdData;
            end
        end
    end

    assign issue.ack     = (state != issueIdle);
    assign issue.op      = opQ[0];
    assign issue.regDest = regDestQ[0];
    assign issue.addr    = addrQ[0];
    assign issue.data    = dataQ[0];

endmodule

//--- logic/ioPortTarget.sv
module ioPortTarget (
    input  logic              clk,
    input  logic              rstN,
    input  logic              portStall,
    ioPortIf.target           port,
    output logic              portWrite,
    output ioPkg::portIdx_t   portWriteIdx,
    output ioPkg::portLine_t  portWriteData,
    output logic              rspValid,
    output ioPkg::regDest_t   rspRegDest,
    output ioPkg::dataWord_t  rspData
);
    import ioPkg::*;

    portLine_t portReg [portCount];
    dataWord_t lineCount;  // line writes since reset.
    cmdKind_e  kind;
    portIdx_t  portIdx;
    wordIdx_t  wordIdx;
    logic      outXfer;

    assign port.req = !portStall;
    assign outXfer  = port.ack && port.req;
    assign kind     = cmdKind_e'(port.op[3:2]);
    assign portIdx  = portIdx_t'(port.addr[4:3]);
    assign wordIdx  = wordIdx_t'(port.addr[2:1]);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < portCount; i++) begin
                portReg[i] <= '0;
            end
            lineCount     <= '0;
            portWrite     <= 1'b0;
            portWriteIdx  <= '0;
            portWriteData <= '0;
            rspValid      <= 1'b0;
            rspRegDest    <= '0;
            rspData       <= '0;
        end else begin
            portWrite <= 1'b0;
            rspValid  <= 1'b0;
            if (outXfer) begin
                if (kind == kindStore) begin
                    portReg[portIdx] <= port.line;
                    lineCount        <= lineCount + 1'b1;
                    portWrite        <= 1'b1;
                    portWriteIdx     <= portIdx;
                    portWriteData    <= port.line;
                end else begin
                    rspValid   <= 1'b1;
                    rspRegDest <= port.regDest;
                    case (kind)
                        kindAtomicLoad: rspData <= portReg[portIdx][wordIdx*dataWidth +: dataWidth];
                        kindStatusLoad: rspData <= lineCount;
                        default:        rspData <= '0;  // opcode kind 00.
                    endcase
                end
            end
        end
    end

endmodule

//--- logic/ioSubsystem.sv
module ioSubsystem (
    input  logic              clk,
    input  logic              rstN,

    input  logic              cmdValid,
    output logic              cmdReady,
    input  ioPkg::minorOp_t   cmdOp,
    input  ioPkg::regDest_t   cmdRegDest,
    input  ioPkg::dataWord_t  cmdAddr,
    input  ioPkg::dataWord_t  cmdData,

    output logic              portWrite,
    output ioPkg::portIdx_t   portWriteIdx,
    output ioPkg::portLine_t  portWriteData,
    output logic              rspValid,
    output ioPkg::regDest_t   rspRegDest,
    output ioPkg::dataWord_t  rspData,
    input  logic              portStall
);

    ioIssueIf issueBus ();
    ioPortIf  portBus ();

    ioCommandIssuer uIssuer (
        .clk        (clk),
        .rstN       (rstN),
        .cmdValid   (cmdValid),
        .cmdReady   (cmdReady),
        .cmdOp      (cmdOp),
        .cmdRegDest (cmdRegDest),
        .cmdAddr    (cmdAddr),
        .cmdData    (cmdData),
        .issue      (issueBus.issuer)
    );

    ioCommandBuffer uBuffer (
        .clk   (clk),
        .rstN  (rstN),
        .issue (issueBus.buffer),
        .port  (portBus.buffer)
    );

    ioPortTarget uTarget (
        .clk           (clk),
        .rstN          (rstN),
        .portStall     (portStall),
        .port          (portBus.target),
        .portWrite     (portWrite),
        .portWriteIdx  (portWriteIdx),
        .portWriteData (portWriteData),
        .rspValid      (rspValid),
        .rspRegDest    (rspRegDest),
        .rspData       (rspData)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the I/O subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ioSubsystemTb \
    -f sources.f \
    -o ioSubsystemSim

./obj_dir/ioSubsystemSim

//--- sources.f
common/ioPkg.sv
common/ioIssueIf.sv
common/ioPortIf.sv
cmdbuffer/ioStoreAlign.sv
issue/ioCommandIssuer.sv
cmdbuffer/ioCommandBuffer.sv
logic/ioPortTarget.sv
logic/ioSubsystem.sv
tests/ioSubsystem_checker.sv
tests/ioSubsystemTb.sv

//--- tests/ioSubsystemTb.sv
module ioSubsystemTb;
    import ioPkg::*;

    localparam int cyclesPerEntry = 200;
    localparam int resetCycles    = 16;

    typedef struct {
        string     name;
        minorOp_t  op;
        regDest_t  regDest;
        dataWord_t addr;
        dataWord_t data;
        int        stall;  // cycles of portStall starting with this entry.
    } stimEntry_t;

    typedef struct {
        string     name;
        logic      isLine;
        portIdx_t  idx;
        portLine_t line;
        regDest_t  regDest;
        dataWord_t data;
    } expResult_t;

    logic      clk;
    logic      rstN;
    logic      cmdValid;
    logic      cmdReady;
    minorOp_t  cmdOp;
    regDest_t  cmdRegDest;
    dataWord_t cmdAddr;
    dataWord_t cmdData;
    logic      portWrite;
    portIdx_t  portWriteIdx;
    portLine_t portWriteData;
    logic      rspValid;
    regDest_t  rspRegDest;
    dataWord_t rspData;
    logic      portStall;

    stimEntry_t stimTable [$];
    expResult_t expected [$];
    logic [7:0] modelBytes [portBytes];  // gathered line with byte 0 lowest.
    portLine_t  modelPort [portCount];
    dataWord_t  modelCount;
    int         cycle;
    int         stallEnd;
    logic       sawBackPressure;

    ioSubsystem u_dut (
        .clk           (clk),
        .rstN          (rstN),
        .cmdValid      (cmdValid),
        .cmdReady      (cmdReady),
        .cmdOp         (cmdOp),
        .cmdRegDest    (cmdRegDest),
        .cmdAddr       (cmdAddr),
        .cmdData       (cmdData),
        .portWrite     (portWrite),
        .portWriteIdx  (portWriteIdx),
        .portWriteData (portWriteData),
        .rspValid      (rspValid),
        .rspRegDest    (rspRegDest),
        .rspData       (rspData),
        .portStall     (portStall)
    );

    bind ioCommandBuffer ioSubsystem_checker uChecker (
        .clk     (clk),
        .rstN    (rstN),
        .inReq   (issue.req),
        .outAck  (port.ack),
        .outReq  (port.req),
        .op      (port.op),
        .regDest (port.regDest),
        .addr    (port.addr),
        .line    (port.line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic addEntry(input string name, input minorOp_t op, input regDest_t rd,
                            input dataWord_t addr, input int stall);
        stimEntry_t e;
        e.name    = name;
        e.op      = op;
        e.regDest = rd;
        e.addr    = addr;
        e.data    = dataWord_t'($urandom());
        e.stall   = stall;
        stimTable.push_back(e);
    endtask

    // op bits [3:2] give the kind (01 store, 10 atomic, 11 status), [1:0] the size.
    task automatic buildTable();
        addEntry("hw0",   4'b0101, 4'd0, 16'h0010, 0);
        addEntry("hw1",   4'b0101, 4'd0, 16'h0012, 0);
        addEntry("hw2",   4'b0101, 4'd0, 16'h0014, 0);
        addEntry("hw3",   4'b0101, 4'd0, 16'h0016, 0);
        addEntry("bLo3",  4'b0100, 4'd0, 16'h0016, 0);  // no release yet.
        addEntry("bHi3",  4'b0100, 4'd0, 16'h0017, 0);
        addEntry("p1w0",  4'b0101, 4'd0, 16'h0008, 0);
        addEntry("p1w1",  4'b0100, 4'd0, 16'h000A, 0);
        addEntry("p1w2",  4'b0101, 4'd0, 16'h000C, 0);
        addEntry("p1lo3", 4'b0100, 4'd0, 16'h000E, 0);
        addEntry("ld2w1", 4'b1001, 4'd5, 16'h0012, 0);
        addEntry("p1hi3", 4'b0100, 4'd0, 16'h000F, 0);
        addEntry("stat",  4'b1101, 4'd9, 16'h0000, 0);
        addEntry("oth",   4'b0001, 4'd3, 16'h0000, 0);
        addEntry("s3w3",  4'b0101, 4'd0, 16'h001E, 20);
        addEntry("s3ld",  4'b1001, 4'd7, 16'h001E, 0);
        addEntry("s3st",  4'b1101, 4'd2, 16'h0000, 0);
        addEntry("s3w0",  4'b0101, 4'd0, 16'h0018, 0);
        addEntry("s3w1",  4'b0111, 4'd0, 16'h001A, 0);  // wide size acts as half.
        addEntry("s3oth", 4'b0000, 4'd1, 16'h0000, 0);
    endtask

    function automatic portLine_t modelLine();
        portLine_t l;
        for (int i = 0; i < portBytes; i++) begin
            l[i*8 +: 8] = modelBytes[i];
        end
        return l;
    endfunction

    task automatic modelCommand(input stimEntry_t e);
        cmdKind_e   kind;
        logic       halfSize;
        portIdx_t   pIdx;
        wordIdx_t   wIdx;
        int         lo;
        expResult_t r;
        kind      = cmdKind_e'(e.op[3:2]);
        halfSize  = (e.op[1:0] != 2'b00);
        pIdx      = e.addr[4:3];
        wIdx      = e.addr[2:1];
        r.name    = e.name;
        r.isLine  = 1'b0;
        r.idx     = pIdx;
        r.line    = '0;
        r.regDest = e.regDest;
        r.data    = '0;
        if (kind == kindStore) begin
            if (halfSize) begin
                lo = int'(wIdx) * 2;
                modelBytes[lo]     = e.data[7:0];
                modelBytes[lo + 1] = e.data[15:8];
            end else begin
                modelBytes[e.addr[2:0]] = e.data[7:0];
            end
            // writing byte 7 of the line sends it to the port.
            if (wIdx == 2'd3 && (halfSize || e.addr[0])) begin
                r.isLine        = 1'b1;
                r.line          = modelLine();
                modelPort[pIdx] = r.line;
                modelCount      = modelCount + 16'd1;
                expected.push_back(r);
            end
        end else begin
            case (kind)
                kindAtomicLoad: r.data = modelPort[pIdx][int'(wIdx) * dataWidth +: dataWidth];
                kindStatusLoad: r.data = modelCount;
                default:        r.data = '0;
            endcase
            expected.push_back(r);
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
        cycle++;
        if (portStall && cycle >= stallEnd) begin
            portStall = 1'b0;
        end
    endtask

    task automatic postCommand(input stimEntry_t e);
        if (e.stall > 0) begin
            portStall = 1'b1;
            stallEnd  = cycle + e.stall;
        end
        modelCommand(e);
        cmdValid   = 1'b1;
        cmdOp      = e.op;
        cmdRegDest = e.regDest;
        cmdAddr    = e.addr;
        cmdData    = e.data;
        while (!cmdReady) begin
            if (portStall) begin
                sawBackPressure = 1'b1;
            end
            stepCycle();
        end
        stepCycle();  // accepted on this edge.
        cmdValid = 1'b0;
    endtask

    task automatic checkLine(input string name, input portIdx_t expIdx, input portLine_t expLine);
        if (portWriteIdx !== expIdx) begin
            abortRun($sformatf("[FAIL] %s: portWriteIdx expected %0d, actual %0d",
                               name, expIdx, portWriteIdx));
        end else if (portWriteData !== expLine) begin
            abortRun($sformatf("[FAIL] %s: portWriteData expected %h, actual %h",
                               name, expLine, portWriteData));
        end
    endtask

    task automatic checkRsp(input string name, input regDest_t expRd, input dataWord_t expData);
        if (rspRegDest !== expRd) begin
            abortRun($sformatf("[FAIL] %s: rspRegDest expected %0d, actual %0d",
                               name, expRd, rspRegDest));
        end else if (rspData !== expData) begin
            abortRun($sformatf("[FAIL] %s: rspData expected %h, actual %h",
                               name, expData, rspData));
        end
    endtask

    task automatic checkIdle(input logic writePulse, input logic rspPulse);
        if (writePulse) begin
            abortRun("portWrite pulsed while no result was outstanding");
        end else if (rspPulse) begin
            abortRun("rspValid pulsed while no result was outstanding");
        end
    endtask

    task automatic handlePulse();
        expResult_t r;
        if (portWrite && rspValid) begin
            abortRun("portWrite and rspValid pulsed in the same cycle");
        end else if (expected.size() == 0) begin
            checkIdle(portWrite, rspValid);
        end else begin
            r = expected.pop_front();
            if (r.isLine && !portWrite) begin
                abortRun($sformatf("a response arrived where %s should write a line", r.name));
            end else if (!r.isLine && !rspValid) begin
                abortRun($sformatf("a line write arrived where %s should respond", r.name));
            end else if (r.isLine) begin
                checkLine(r.name, r.idx, r.line);
            end else begin
                checkRsp(r.name, r.regDest, r.data);
            end
        end
    endtask

    // result pulses are picked up mid-cycle.
    initial begin
        forever begin
            @(negedge clk);
            if (rstN === 1'b1 && (portWrite || rspValid)) begin
                handlePulse();
            end
        end
    end

    initial begin
        @(posedge clk);
        repeat (resetCycles + cyclesPerEntry * stimTable.size()) @(posedge clk);
        abortRun("watchdog expired, the DUT stopped answering and the run hung");
    end

    initial begin
        int drainWait;
        rstN            = 1'b0;
        cmdValid        = 1'b0;
        cmdOp           = '0;
        cmdRegDest      = '0;
        cmdAddr         = '0;
        cmdData         = '0;
        portStall       = 1'b0;
        cycle           = 0;
        stallEnd        = 0;
        sawBackPressure = 1'b0;
        modelCount      = '0;
        for (int i = 0; i < portBytes; i++) begin
            modelBytes[i] = '0;
        end
        for (int i = 0; i < portCount; i++) begin
            modelPort[i] = '0;
        end
        void'($urandom(36));
        buildTable();
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        if (cmdReady !== 1'b1) begin
            abortRun("cmdReady is not high after reset");
        end
        foreach (stimTable[i]) begin
            postCommand(stimTable[i]);
        end
        drainWait = 0;
        while (expected.size() != 0 && drainWait < cyclesPerEntry) begin
            stepCycle();
            drainWait++;
        end
        repeat (10) stepCycle();  // catch stray pulses.
        if (expected.size() != 0) begin
            abortRun($sformatf("%0d expected results never arrived", expected.size()));
        end else if (!sawBackPressure) begin
            abortRun("cmdReady never dropped while portStall was held");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- tests/ioSubsystem_checker.sv
module ioSubsystem_checker (
    input logic             clk,
    input logic             rstN,
    input logic             inReq,
    input logic             outAck,
    input logic             outReq,
    input ioPkg::minorOp_t  op,
    input ioPkg::regDest_t  regDest,
    input ioPkg::dataWord_t addr,
    input ioPkg::portLine_t line
);

    // only one command may be in flight.
    assert property (@(posedge clk) disable iff (!rstN) !(inReq && outAck))
        else $error("buffer input req and output ack high together");

    // a stalled target sees a steady command.
    assert property (@(posedge clk) disable iff (!rstN)
        (outAck && !outReq) |=> ($stable(op) && $stable(regDest) && $stable(addr)
                                  && $stable(line)))
        else $error("port fields changed while ack was held under stall");

    assert property (@(posedge clk) !rstN |-> !outAck)
        else $error("port ack high during reset");

endmodule
